//--- sources.f
design/zxuno_pkg.sv
design/zxuno_reg_if.sv
design/io_cycle_fsm.sv
design/config_regs.sv
design/raster_timer.sv
design/zxuno_ctrl.sv
testbench/tb_zxuno_ctrl.sv

//--- Makefile
TOP := tb_zxuno_ctrl

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing -f sources.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf obj_dir

//--- testbench/tb_zxuno_ctrl.sv
`timescale 1ns/1ns

module tb_zxuno_ctrl;
   import zxuno_pkg::*;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 16;
   localparam int LINE_GAP     = 40;
   localparam int N_ADDR_LOOPS = 8;
   localparam int N_CFG_LOOPS  = 4;
   // Bus accesses of the tests, reset through vertical retrace
   localparam int N_ACCESS     = 1 + N_ADDR_LOOPS * 2 + N_CFG_LOOPS * 12 + 2 + 8 + 8;
   localparam int N_FRAMES     = 4;
   localparam int N_LINES      = 64;
   localparam int TIMEOUT_NS   = (N_ACCESS * 4 + N_FRAMES * N_LINES * LINE_GAP + RESET_CYCLES)
                                 * CLK_PERIOD * 2;

   logic        clk;
   logic        rst_n;
   logic [15:0] a;
   logic        iorq_n;
   logic        rd_n;
   logic        wr_n;
   byte_t       din;
   logic        line_strobe;
   logic        frame_strobe;
   byte_t       dout;
   logic        oe_n;
   logic        int_n;
   logic        vga_enable;
   logic        scanlines_enable;
   logic [2:0]  freq_option;
   logic [1:0]  turbo_enable;
   logic        disable_ay;
   logic        disable_turboay;
   logic        disable_7ffd;
   logic        disable_1ffd;
   logic        disable_romsel7f;
   logic        disable_romsel1f;
   logic        enable_timexmmu;
   logic        disable_spisd;

   byte_t       model_regs [0:255];
   logic [31:0] lfsr_state    = 32'd95807;
   int          checks_passed = 0;
   int          checks_failed = 0;
   int          low_run       = 0;
   int          pulse_len     = 0;
   int          pulse_count   = 0;

   zxuno_ctrl zxuno_ctrl_inst (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // Length in clocks of each finished int_n low pulse
   always @(negedge clk or negedge rst_n) begin
      if (!rst_n) begin
         low_run <= 0;
      end else if (!int_n) begin
         low_run <= low_run + 1;
      end else if (low_run != 0) begin
         pulse_len   <= low_run;
         pulse_count <= pulse_count + 1;
         low_run     <= 0;
      end
   end

   // --------------------------------------------------
   // Random bits and the reference model
   // --------------------------------------------------
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
   endfunction

   task automatic rand_bits(input int n, output byte_t v);
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v[i]       = lfsr_state[0];
      end
   endtask

   // Expected readback of a register index
   // Bit 7 of raster control is live status
   function automatic byte_t expected_reg(input byte_t idx, input logic in_prog);
      byte_t r;
      case (idx)
         REG_SCRATCH, REG_DEVOPTIONS, REG_SCANDBLCTRL, REG_RASTERLINE: r = model_regs[idx];
         REG_RASTERCTRL: r = {in_prog, model_regs[idx][6:0]};
         default:        r = BYTE_IDLE;
      endcase
      return r;
   endfunction

   function automatic logic reg_known(input byte_t idx);
      return (idx == REG_SCRATCH) || (idx == REG_DEVOPTIONS) || (idx == REG_SCANDBLCTRL) ||
             (idx == REG_RASTERLINE) || (idx == REG_RASTERCTRL);
   endfunction

   // --------------------------------------------------
   // Compare tasks
   // --------------------------------------------------
   task automatic check_byte(input string name, input byte_t exp, input byte_t act);
      if (exp === act) begin
         checks_passed++;
      end else begin
         checks_failed++;
         $display("Fail %s: expected %02h, actual %02h", name, exp, act);
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      if (exp === act) begin
         checks_passed++;
      end else begin
         checks_failed++;
         $display("Fail %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic report_test(input string name, input int fails_before);
      if (checks_failed == fails_before) begin
         $display("%s: passed", name);
      end else begin
         $display("%s: %0d checks failed", name, checks_failed - fails_before);
      end
   endtask

   // Decoded enables against the register map layout
   task automatic check_outputs(input string name);
      check_byte({name, " devopts"}, model_regs[REG_DEVOPTIONS],
                 {disable_spisd, enable_timexmmu, disable_romsel1f, disable_romsel7f,
                  disable_1ffd, disable_7ffd, disable_turboay, disable_ay});
      check_byte({name, " scndbl"}, model_regs[REG_SCANDBLCTRL] & 8'hDF,
                 {turbo_enable, 1'b0, freq_option, scanlines_enable, vga_enable});
   endtask

   // --------------------------------------------------
   // Bus tasks
   // --------------------------------------------------
   // All start and end on a falling edge
   task io_write(input logic [15:0] port, input byte_t data);
      a      = port;
      din    = data;
      iorq_n = 1'b0;
      wr_n   = 1'b0;
      repeat (3) @(negedge clk);
      iorq_n = 1'b1;
      wr_n   = 1'b1;
      @(negedge clk);
   endtask

   task io_read(input logic [15:0] port, output byte_t data, output logic oe);
      a      = port;
      iorq_n = 1'b0;
      rd_n   = 1'b0;
      #(CLK_PERIOD / 4);
      data = dout;
      oe   = oe_n;
      @(negedge clk);
      iorq_n = 1'b1;
      rd_n   = 1'b1;
      @(negedge clk);
   endtask

   task write_reg(input byte_t idx, input byte_t data);
      io_write(PORT_ADDR_REG, idx);
      io_write(PORT_DATA_REG, data);
      model_regs[idx] = data;
   endtask

   task read_and_check(input string name, input byte_t idx, input logic in_prog);
      byte_t d;
      logic  o;
      io_write(PORT_ADDR_REG, idx);
      io_read(PORT_DATA_REG, d, o);
      check_byte(name, expected_reg(idx, in_prog), d);
      check_level({name, " oe_n"}, !reg_known(idx), o);
   endtask

   task pulse_strobe(input logic is_frame);
      if (is_frame) begin
         frame_strobe = 1'b1;
      end else begin
         line_strobe = 1'b1;
      end
      @(negedge clk);
      frame_strobe = 1'b0;
      line_strobe  = 1'b0;
   endtask

   initial begin
      #(TIMEOUT_NS);
      $display("Timed out after %0d ns, a test did not finish", TIMEOUT_NS);
      $display("Test failures found");
      $finish;
   end

   // --------------------------------------------------
   // Tests
   // --------------------------------------------------
   initial begin
      byte_t v;
      byte_t d;
      logic  o;
      int    n_line;
      int    base;
      int    fails_before;

      rst_n        = 1'b0;
      a            = '0;
      iorq_n       = 1'b1;
      rd_n         = 1'b1;
      wr_n         = 1'b1;
      din          = '0;
      line_strobe  = 1'b0;
      frame_strobe = 1'b0;
      for (int i = 0; i < 256; i++) begin
         model_regs[i] = REG_RST;
      end
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      fails_before = checks_failed;
      check_level("reset oe_n", 1'b1, oe_n);
      check_level("reset int_n", 1'b1, int_n);
      check_outputs("reset");
      io_read(PORT_ADDR_REG, d, o);
      check_byte("reset address register", 8'h00, d);
      check_level("reset address oe_n", 1'b0, o);
      report_test("reset values", fails_before);

      fails_before = checks_failed;
      repeat (N_ADDR_LOOPS) begin
         rand_bits(8, v);
         io_write(PORT_ADDR_REG, v);
         io_read(PORT_ADDR_REG, d, o);
         check_byte("address register", v, d);
         check_level("address oe_n", 1'b0, o);
      end
      report_test("address register", fails_before);

      fails_before = checks_failed;
      repeat (N_CFG_LOOPS) begin
         rand_bits(8, v);
         write_reg(REG_SCRATCH, v);
         read_and_check("scratch", REG_SCRATCH, 1'b0);
         rand_bits(8, v);
         write_reg(REG_DEVOPTIONS, v);
         read_and_check("devoptions", REG_DEVOPTIONS, 1'b0);
         rand_bits(8, v);
         write_reg(REG_SCANDBLCTRL, v);
         read_and_check("scandblctrl", REG_SCANDBLCTRL, 1'b0);
         check_outputs("config");
      end
      read_and_check("unused index", 8'h00, 1'b0);
      report_test("config registers", fails_before);

      // Raster line N with vertical retrace masked
      fails_before = checks_failed;
      rand_bits(6, v);
      n_line = {24'd0, v};
      if (n_line == 0) begin
         n_line = 1;
      end
      write_reg(REG_RASTERLINE, n_line[7:0]);
      write_reg(REG_RASTERCTRL, 8'h06);
      read_and_check("rasterline", REG_RASTERLINE, 1'b0);
      base = pulse_count;
      pulse_strobe(1'b1);
      for (int i = 1; i <= n_line; i++) begin
         repeat (LINE_GAP) @(negedge clk);
         if (i == n_line) begin
            check_level("raster int_n before line", 1'b1, int_n);
            check_level("raster no early pulse", 1'b1, pulse_count == base);
         end
         pulse_strobe(1'b0);
      end
      read_and_check("raster in_progress", REG_RASTERCTRL, 1'b1);
      repeat (LINE_GAP) @(negedge clk);
      check_level("raster one pulse", 1'b1, pulse_count == base + 1);
      check_byte("raster pulse length", 8'(INT_CYCLES), 8'(pulse_len));
      report_test("raster interrupt", fails_before);

      fails_before = checks_failed;
      write_reg(REG_RASTERCTRL, 8'h00);
      base = pulse_count;
      repeat (2) begin
         pulse_strobe(1'b1);
         read_and_check("vretrace in_progress", REG_RASTERCTRL, 1'b0);
         repeat (LINE_GAP) @(negedge clk);
         check_byte("vretrace pulse length", 8'(INT_CYCLES), 8'(pulse_len));
      end
      check_level("vretrace pulse count", 1'b1, pulse_count == base + 2);
      // Both sources off
      write_reg(REG_RASTERCTRL, 8'h04);
      base = pulse_count;
      pulse_strobe(1'b1);
      repeat (4) begin
         repeat (LINE_GAP) @(negedge clk);
         pulse_strobe(1'b0);
      end
      repeat (LINE_GAP) @(negedge clk);
      check_level("masked int_n", 1'b1, int_n);
      check_level("masked no pulse", 1'b1, pulse_count == base);
      report_test("vretrace interrupt", fails_before);

      $display("Checks passed: %0d, checks failed: %0d", checks_passed, checks_failed);
      if (checks_failed == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

//--- design/zxuno_ctrl.sv
`timescale 1ns/1ns

module zxuno_ctrl (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [15:0]      a,
   input  logic             iorq_n,
   input  logic             rd_n,
   input  logic             wr_n,
   input  zxuno_pkg::byte_t din,
   input  logic             line_strobe,
   input  logic             frame_strobe,
   output zxuno_pkg::byte_t dout,
   output logic             oe_n,
   output logic             int_n,
   // Scandoubler control
   output logic             vga_enable,
   output logic             scanlines_enable,
   output logic [2:0]       freq_option,
   output logic [1:0]       turbo_enable,
   // Device enables
   output logic             disable_ay,
   output logic             disable_turboay,
   output logic             disable_7ffd,
   output logic             disable_1ffd,
   output logic             disable_romsel7f,
   output logic             disable_romsel1f,
   output logic             enable_timexmmu,
   output logic             disable_spisd
);
   import zxuno_pkg::*;

   byte_t    addr_dout;
   byte_t    cfg_dout;
   byte_t    raster_dout;
   logic     oe_n_addr;
   logic     oe_n_cfg;
   logic     oe_n_raster;
   devopts_u devopts;
   scndbl_u  scndbl;

   zxuno_reg_if reg_bus ();

   io_cycle_fsm io_cycle_fsm_inst (
      .clk    (clk),
      .rst_n  (rst_n),
      .a      (a),
      .iorq_n (iorq_n),
      .rd_n   (rd_n),
      .wr_n   (wr_n),
      .din    (din),
      .dout   (addr_dout),
      .oe_n   (oe_n_addr),
      .bus    (reg_bus.fsm)
   );

   config_regs config_regs_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .bus     (reg_bus.regs),
      .dout    (cfg_dout),
      .oe_n    (oe_n_cfg),
      .devopts (devopts),
      .scndbl  (scndbl)
   );

   raster_timer raster_timer_inst (
      .clk          (clk),
      .rst_n        (rst_n),
      .line_strobe  (line_strobe),
      .frame_strobe (frame_strobe),
      .bus          (reg_bus.regs),
      .dout         (raster_dout),
      .oe_n         (oe_n_raster),
      .int_n        (int_n)
   );

   // --------------------------------------------------
   // CPU read data, first enabled source wins
   // --------------------------------------------------
   always_comb begin
      oe_n = 1'b0;
      case (1'b0)
         oe_n_addr:   dout = addr_dout;
         oe_n_cfg:    dout = cfg_dout;
         oe_n_raster: dout = raster_dout;
         default: begin
            dout = BYTE_IDLE;
            oe_n = 1'b1;
         end
      endcase
   end

   // Union fields out to plain ports
   assign vga_enable       = scndbl.f.vga_enable;
   assign scanlines_enable = scndbl.f.scanlines_enable;
   assign freq_option      = scndbl.f.freq_option;
   assign turbo_enable     = scndbl.f.turbo_enable;
   assign disable_ay       = devopts.f.disable_ay;
   assign disable_turboay  = devopts.f.disable_turboay;
   assign disable_7ffd     = devopts.f.disable_7ffd;
   assign disable_1ffd     = devopts.f.disable_1ffd;
   assign disable_romsel7f = devopts.f.disable_romsel7f;
   assign disable_romsel1f = devopts.f.disable_romsel1f;
   assign enable_timexmmu  = devopts.f.enable_timexmmu;
   assign disable_spisd    = devopts.f.disable_spisd;

endmodule

//--- design/raster_timer.sv
`timescale 1ns/1ns

module raster_timer (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             line_strobe,
   input  logic             frame_strobe,
   zxuno_reg_if.regs        bus,
   output zxuno_pkg::byte_t dout,
   output logic             oe_n,
   output logic             int_n
);
   import zxuno_pkg::*;

   byte_t                rline;
   rasterctrl_u          rctrl;
   rasterctrl_u          rctrl_rd;
   line_t                raster_line;
   line_t                line_cnt;
   line_t                line_next;
   logic [INT_CNT_W-1:0] int_cnt;
   logic                 raster_pulse;
   logic                 in_progress;
   logic                 vretrace_hit;
   logic                 raster_hit;

   // --------------------------------------------------
   // Raster registers
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rline     <= REG_RST;
         rctrl.raw <= REG_RST;
      end else if (bus.regwr) begin
         if (bus.zxuno_addr == REG_RASTERLINE) begin
            rline <= bus.wdata;
         end
         // Bit 7 is status only and never stored
         if (bus.zxuno_addr == REG_RASTERCTRL) begin
            rctrl.raw <= {1'b0, bus.wdata[6:0]};
         end
      end
   end

   assign raster_line = {rctrl.f.line_msb, rline};

   // --------------------------------------------------
   // Scanline counter, frame strobe wins
   // --------------------------------------------------
   assign line_next = frame_strobe ? '0 : line_cnt + 1'b1;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         line_cnt <= '0;
      end else if (frame_strobe || line_strobe) begin
         line_cnt <= line_next;
      end
   end

   // Triggers are judged on the value the count is about to take
   assign vretrace_hit = frame_strobe && !rctrl.f.vretrace_disable;
   assign raster_hit   = (frame_strobe || line_strobe) && rctrl.f.raster_enable &&
                         (line_next == raster_line);

   // --------------------------------------------------
   // Interrupt pulse timer
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         int_cnt      <= '0;
         raster_pulse <= 1'b0;
      end else if (int_cnt == '0) begin
         if (vretrace_hit || raster_hit) begin
            int_cnt      <= INT_CNT_W'(INT_CYCLES);
            raster_pulse <= raster_hit;
         end
      end else begin
         // New triggers are dropped while the pulse runs
         int_cnt <= int_cnt - 1'b1;
      end
   end

   assign int_n       = (int_cnt == '0);
   assign in_progress = raster_pulse && (int_cnt != '0);

   // Readback with live status bit
   always_comb begin
      rctrl_rd               = rctrl;
      rctrl_rd.f.in_progress = in_progress;
      dout                   = BYTE_IDLE;
      oe_n                   = 1'b1;
      if (bus.regrd && (bus.zxuno_addr == REG_RASTERLINE)) begin
         dout = rline;
         oe_n = 1'b0;
      end else if (bus.regrd && (bus.zxuno_addr == REG_RASTERCTRL)) begin
         dout = rctrl_rd.raw;
         oe_n = 1'b0;
      end
   end

endmodule

//--- design/config_regs.sv
`timescale 1ns/1ns

module config_regs (
   input  logic                clk,
   input  logic                rst_n,
   zxuno_reg_if.regs           bus,
   output zxuno_pkg::byte_t    dout,
   output logic                oe_n,
   output zxuno_pkg::devopts_u devopts,
   output zxuno_pkg::scndbl_u  scndbl
);
   import zxuno_pkg::*;

   byte_t    scratch;
   devopts_u devopts_reg;
   scndbl_u  scndbl_reg;

   // --------------------------------------------------
   // Register writes
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         scratch         <= REG_RST;
         devopts_reg.raw <= REG_RST;
         scndbl_reg.raw  <= REG_RST;
      end else if (bus.regwr) begin
         case (bus.zxuno_addr)
            REG_SCRATCH: begin
               scratch <= bus.wdata;
            end
            REG_DEVOPTIONS: begin
               devopts_reg.raw <= bus.wdata;
            end
            REG_SCANDBLCTRL: begin
               scndbl_reg.raw <= bus.wdata;
            end
            default: begin
            end
         endcase
      end
   end

   // --------------------------------------------------
   // Readback
   // --------------------------------------------------
   always_comb begin
      dout = BYTE_IDLE;
      oe_n = 1'b1;
      if (bus.regrd) begin
         case (bus.zxuno_addr)
            REG_SCRATCH: begin
               dout = scratch;
               oe_n = 1'b0;
            end
            REG_DEVOPTIONS: begin
               dout = devopts_reg.raw;
               oe_n = 1'b0;
            end
            REG_SCANDBLCTRL: begin
               dout = scndbl_reg.raw;
               oe_n = 1'b0;
            end
            default: begin
            end
         endcase
      end
   end

   // Decoded fields go straight out
   assign devopts = devopts_reg;
   assign scndbl  = scndbl_reg;

endmodule

//--- design/io_cycle_fsm.sv
`timescale 1ns/1ns

module io_cycle_fsm (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [15:0]      a,
   input  logic             iorq_n,
   input  logic             rd_n,
   input  logic             wr_n,
   input  zxuno_pkg::byte_t din,
   output zxuno_pkg::byte_t dout,
   output logic             oe_n,
   zxuno_reg_if.fsm         bus
);
   import zxuno_pkg::*;

   logic [ST_W-1:0] state;
   byte_t           addr_reg;
   logic            data_wr;
   logic            hit_addr;
   logic            hit_data;
   logic            io_rd;
   logic            io_wr;

   // --------------------------------------------------
   // Port decode
   // --------------------------------------------------
   assign hit_addr = (a == PORT_ADDR_REG);
   assign hit_data = (a == PORT_DATA_REG);
   assign io_rd    = !iorq_n && !rd_n;
   assign io_wr    = !iorq_n && !wr_n;

   // --------------------------------------------------
   // Write cycle FSM
   // --------------------------------------------------
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= ST_IDLE;
         addr_reg <= REG_RST;
         data_wr  <= 1'b0;
      end else begin
         case (state)
            ST_IDLE: begin
               if (io_wr && (hit_addr || hit_data)) begin
                  state   <= ST_STROBE;
                  data_wr <= hit_data;
                  // Address register loads on the edge that sees the write
                  if (hit_addr) begin
                     addr_reg <= din;
                  end
               end
            end
            ST_STROBE: begin
               state <= ST_WAIT_END;
            end
            ST_WAIT_END: begin
               // Hold off until the CPU ends the I/O cycle
               if (iorq_n) begin
                  state <= ST_IDLE;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // Register bank side
   assign bus.zxuno_addr = addr_reg;
   assign bus.regrd      = io_rd && hit_data;
   assign bus.regwr      = (state == ST_STROBE) && data_wr;
   assign bus.wdata      = din;

   // Address register readback
   assign dout = addr_reg;
   assign oe_n = !(io_rd && hit_addr);

endmodule

//--- design/zxuno_reg_if.sv
`timescale 1ns/1ns

interface zxuno_reg_if;
   import zxuno_pkg::*;

   byte_t zxuno_addr;
   // Level for the whole data port read
   logic  regrd;
   // One clock per data port write
   logic  regwr;
   byte_t wdata;

   modport fsm (
      output zxuno_addr, regrd, regwr, wdata
   );

   modport regs (
      input zxuno_addr, regrd, regwr, wdata
   );

endinterface

//--- design/zxuno_pkg.sv
package zxuno_pkg;

   typedef logic [7:0] byte_t;
   typedef logic [8:0] line_t;

   // CPU I/O ports of the register bank
   localparam logic [15:0] PORT_ADDR_REG = 16'hFC3B;
   localparam logic [15:0] PORT_DATA_REG = 16'hFD3B;

   // Register indices
   localparam byte_t REG_SCANDBLCTRL = 8'h0B;
   localparam byte_t REG_RASTERLINE  = 8'h0C;
   localparam byte_t REG_RASTERCTRL  = 8'h0D;
   localparam byte_t REG_DEVOPTIONS  = 8'h0E;
   localparam byte_t REG_SCRATCH     = 8'hFE;

   // Reset value of every register, and the floating bus value
   localparam byte_t REG_RST   = 8'h00;
   localparam byte_t BYTE_IDLE = 8'hFF;

   // Raster interrupt pulse
   localparam int INT_CYCLES = 32;
   localparam int INT_CNT_W  = $clog2(INT_CYCLES + 1);

   // I/O cycle FSM encoding
   localparam int ST_W = 2;
   localparam logic [ST_W-1:0] ST_IDLE     = 2'd0;
   localparam logic [ST_W-1:0] ST_STROBE   = 2'd1;
   localparam logic [ST_W-1:0] ST_WAIT_END = 2'd2;

   // Device options, bit 0 is disable_ay
   typedef union packed {
      byte_t raw;
      struct packed {
         logic disable_spisd;
         logic enable_timexmmu;
         logic disable_romsel1f;
         logic disable_romsel7f;
         logic disable_1ffd;
         logic disable_7ffd;
         logic disable_turboay;
         logic disable_ay;
      } f;
   } devopts_u;

   // Scandoubler control
   typedef union packed {
      byte_t raw;
      struct packed {
         logic [1:0] turbo_enable;
         logic       reserved;
         logic [2:0] freq_option;
         logic       scanlines_enable;
         logic       vga_enable;
      } f;
   } scndbl_u;

   // Raster control, bit 7 is read-only
   typedef union packed {
      byte_t raw;
      struct packed {
         logic       in_progress;
         logic [3:0] reserved;
         logic       vretrace_disable;
         logic       raster_enable;
         logic       line_msb;
      } f;
   } rasterctrl_u;

endpackage
